//--- rf_pkg.sv
`default_nettype none

package rf_pkg;

    // RV32I integer file
    localparam int NUM_REGS = 32;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    // decode side read request, held by decode while stalled
    typedef struct packed {
        logic      valid;
        reg_addr_t rs1;
        logic      re1;
        reg_addr_t rs2;
        logic      re2;
    } rd_req_t;

    // pending write of one in-flight stage
    // is_load marks data not yet available (ex stage only)
    typedef struct packed {
        logic      we;
        logic      is_load;
        reg_addr_t waddr;
        xlen_t     wdata;
    } stage_wr_t;

    // operand pair handed to execute
    typedef struct packed {
        logic  valid;
        xlen_t op_a;
        xlen_t op_b;
    } operand_t;

    // operand source, youngest stage wins
    typedef enum logic [1:0] {
        FWD_FILE,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rf_pkg::*; (
    input  wire            clk,
    input  wire            rst_n_i,

    // read ports
    input  wire reg_addr_t raddr1_i,
    input  wire reg_addr_t raddr2_i,
    output xlen_t          rdata1_o,
    output xlen_t          rdata2_o,

    // write port from write-back
    input  wire stage_wr_t wr_i
);

    xlen_t regs_q [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.waddr != '0)) begin
            // x0 never written
            regs_q[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // combinational read, x0 reads zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

    // a load only exists in ex, by write-back its data must be resolved
    a_wb_no_load: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !wr_i.is_load
    ) else $error("reg_file: load flag seen on write-back port");

endmodule

`default_nettype wire

//--- bypass_select.sv
`timescale 1ns/1ps
`default_nettype none

module bypass_select import rf_pkg::*; (
    input  wire rd_req_t   req_i,

    // in-flight writes from the youngest stage down
    input  wire stage_wr_t ex_wr_i,
    input  wire stage_wr_t mem_wr_i,
    input  wire stage_wr_t wb_wr_i,

    output fwd_sel_e       sel1_o,
    output fwd_sel_e       sel2_o,
    output xlen_t          fwd_data1_o,
    output xlen_t          fwd_data2_o,
    output logic           load_use_o
);

    typedef struct packed {
        fwd_sel_e sel;
        xlen_t    data;
        logic     hazard;
    } fwd_res_t;

    // priority compare of one source against ex, mem and wb
    function automatic fwd_res_t resolve(
        input reg_addr_t rs,
        input logic      re,
        input stage_wr_t ex,
        input stage_wr_t mem,
        input stage_wr_t wb
    );
        fwd_res_t res;
        res.sel    = FWD_FILE;
        res.data   = '0;
        res.hazard = 1'b0;
        if (re && (rs != '0)) begin
            if (ex.we && (ex.waddr == rs)) begin
                // a load in ex has no data yet so older matches do not help
                res.sel    = FWD_EX;
                res.data   = ex.wdata;
                res.hazard = ex.is_load;
            end else if (mem.we && (mem.waddr == rs)) begin
                res.sel  = FWD_MEM;
                res.data = mem.wdata;
            end else if (wb.we && (wb.waddr == rs)) begin
                res.sel  = FWD_WB;
                res.data = wb.wdata;
            end
        end
        return res;
    endfunction

    fwd_res_t res1;
    fwd_res_t res2;

    always_comb begin
        res1 = resolve(req_i.rs1, req_i.re1, ex_wr_i, mem_wr_i, wb_wr_i);
        res2 = resolve(req_i.rs2, req_i.re2, ex_wr_i, mem_wr_i, wb_wr_i);
    end

    assign sel1_o      = res1.sel;
    assign sel2_o      = res2.sel;
    assign fwd_data1_o = res1.data;
    assign fwd_data2_o = res2.data;

    // only a real request can stall decode
    assign load_use_o = req_i.valid && (res1.hazard || res2.hazard);

    // mem and wb data is forwarded as is, so only ex may carry a pending load
    always_comb begin
        a_no_older_load: assert final (
            !mem_wr_i.is_load && !wb_wr_i.is_load
        ) else $error("bypass_select: load flag seen on mem or wb stage");
    end

endmodule

`default_nettype wire

//--- issue_reg.sv
`timescale 1ns/1ps
`default_nettype none

module issue_reg import rf_pkg::*; (
    input  wire           clk,
    input  wire           rst_n_i,

    input  wire           req_valid_i,
    input  wire           re1_i,
    input  wire           re2_i,

    // register file data
    input  wire xlen_t    rdata1_i,
    input  wire xlen_t    rdata2_i,

    // forwarding choice
    input  wire fwd_sel_e sel1_i,
    input  wire fwd_sel_e sel2_i,
    input  wire xlen_t    fwd_data1_i,
    input  wire xlen_t    fwd_data2_i,

    input  wire           stall_i,
    input  wire           flush_i,

    output operand_t      issue_o
);

    // file or bypass data, or zero when the source is not read
    function automatic xlen_t pick(
        input logic     re,
        input fwd_sel_e sel,
        input xlen_t    file_data,
        input xlen_t    fwd_data
    );
        if (!re) begin
            return '0;
        end
        return (sel == FWD_FILE) ? file_data : fwd_data;
    endfunction

    operand_t issue_d;

    always_comb begin
        issue_d.valid = req_valid_i && !stall_i && !flush_i;
        issue_d.op_a  = pick(re1_i, sel1_i, rdata1_i, fwd_data1_i);
        issue_d.op_b  = pick(re2_i, sel2_i, rdata2_i, fwd_data2_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_o <= '0;
        end else begin
            // stall or flush leaves a bubble and the operands hold
            issue_o.valid <= issue_d.valid;
            if (issue_d.valid) begin
                issue_o.op_a <= issue_d.op_a;
                issue_o.op_b <= issue_d.op_b;
            end
        end
    end

    // decode holds its request through a stall
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_i |=> (req_valid_i && $stable(re1_i) && $stable(re2_i))
    ) else $error("issue_reg: request dropped or changed while stalled");

endmodule

`default_nettype wire

//--- operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch import rf_pkg::*; (
    input  wire            clk,
    input  wire            rst_n_i,

    // from decode
    input  wire rd_req_t   rd_req_i,

    // from ex, mem, wb
    input  wire stage_wr_t ex_wr_i,
    input  wire stage_wr_t mem_wr_i,
    input  wire stage_wr_t wb_wr_i,

    input  wire            flush_i,

    // to execute
    output operand_t       issue_o,

    // to decode
    output logic           stall_o
);

    xlen_t    rdata1;
    xlen_t    rdata2;

    fwd_sel_e sel1;
    fwd_sel_e sel2;
    xlen_t    fwd_data1;
    xlen_t    fwd_data2;

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rd_req_i.rs1),
        .raddr2_i (rd_req_i.rs2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wr_i     (wb_wr_i)
    );

    // load-use drives the decode stall directly
    bypass_select u_bypass_select (
        .req_i       (rd_req_i),
        .ex_wr_i     (ex_wr_i),
        .mem_wr_i    (mem_wr_i),
        .wb_wr_i     (wb_wr_i),
        .sel1_o      (sel1),
        .sel2_o      (sel2),
        .fwd_data1_o (fwd_data1),
        .fwd_data2_o (fwd_data2),
        .load_use_o  (stall_o)
    );

    issue_reg u_issue_reg (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (rd_req_i.valid),
        .re1_i       (rd_req_i.re1),
        .re2_i       (rd_req_i.re2),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .sel1_i      (sel1),
        .sel2_i      (sel2),
        .fwd_data1_i (fwd_data1),
        .fwd_data2_i (fwd_data2),
        .stall_i     (stall_o),
        .flush_i     (flush_i),
        .issue_o     (issue_o)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam time CLK_PERIOD_NS = 4;
    localparam int  RESET_CYCLES  = 2;

    initial begin
        clk_o = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release away from the rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_operand_fetch import rf_pkg::*; ();

    localparam int  SEED          = 66;
    localparam int  INIT_CYCLES   = 8;
    localparam int  NUM_REQ       = 500;
    localparam int  STALL_FACTOR  = 2;
    localparam time CLK_PERIOD_NS = 4;
    localparam time WATCHDOG_NS   =
        (INIT_CYCLES + NUM_REQ * STALL_FACTOR + 20) * CLK_PERIOD_NS;

    logic      clk;
    logic      rst_n;
    rd_req_t   rd_req_i;
    stage_wr_t ex_wr_i;
    stage_wr_t mem_wr_i;
    stage_wr_t wb_wr_i;
    logic      flush_i;
    operand_t  issue_o;
    logic      stall_o;

    // reference state
    xlen_t     ref_regs [NUM_REGS];
    logic      exp_stall;
    operand_t  exp_issue_d;
    operand_t  exp_issue_q;
    logic      stalled_prev;
    int        n_req;
    int        n_stall;
    int        n_flush;
    int        n_accept;
    int        n_multi;

    tb_clock_gen i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    operand_fetch i_dut (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .rd_req_i (rd_req_i),
        .ex_wr_i  (ex_wr_i),
        .mem_wr_i (mem_wr_i),
        .wb_wr_i  (wb_wr_i),
        .flush_i  (flush_i),
        .issue_o  (issue_o),
        .stall_o  (stall_o)
    );

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                ref_regs[i] <= '0;
            end
        end else if (wb_wr_i.we && (wb_wr_i.waddr != '0)) begin
            ref_regs[wb_wr_i.waddr] <= wb_wr_i.wdata;
        end
    end

    // expected issue one cycle after the request
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_issue_q <= '0;
        end else begin
            exp_issue_q <= exp_issue_d;
        end
    end

    task automatic report_mismatch(input string name, input xlen_t exp, input xlen_t act);
        $display("error: time %0t, %s, expected %h, actual %h", $time, name, exp, act);
        $display(">>> FAIL");
        $fatal(1, "value mismatch on %s", name);
    endtask

    a_stall_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_o == exp_stall
    ) else report_mismatch("stall_o", xlen_t'($sampled(exp_stall)), xlen_t'($sampled(stall_o)));

    a_valid_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_o.valid == exp_issue_q.valid
    ) else report_mismatch("issue_o.valid", xlen_t'($sampled(exp_issue_q.valid)),
                           xlen_t'($sampled(issue_o.valid)));

    a_op_a_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        exp_issue_q.valid |-> (issue_o.op_a == exp_issue_q.op_a)
    ) else report_mismatch("issue_o.op_a", $sampled(exp_issue_q.op_a), $sampled(issue_o.op_a));

    a_op_b_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        exp_issue_q.valid |-> (issue_o.op_b == exp_issue_q.op_b)
    ) else report_mismatch("issue_o.op_b", $sampled(exp_issue_q.op_b), $sampled(issue_o.op_b));

    // youngest matching stage wins before the file
    function automatic xlen_t expect_operand(
        input  logic      re,
        input  reg_addr_t rs,
        output logic      hazard
    );
        stage_wr_t stages [3];
        xlen_t     value;
        logic      found;
        stages[0] = ex_wr_i;
        stages[1] = mem_wr_i;
        stages[2] = wb_wr_i;
        hazard = 1'b0;
        value  = '0;
        found  = 1'b0;
        if (re && (rs != '0)) begin
            value = ref_regs[rs];
            for (int s = 0; s < 3; s++) begin
                if (!found && stages[s].we && (stages[s].waddr == rs)) begin
                    found  = 1'b1;
                    value  = stages[s].wdata;
                    hazard = stages[s].is_load;
                end
            end
        end
        return value;
    endfunction

    task automatic compute_expected();
        logic  haz1;
        logic  haz2;
        xlen_t op1;
        xlen_t op2;
        int    hits;
        op1 = expect_operand(rd_req_i.re1, rd_req_i.rs1, haz1);
        op2 = expect_operand(rd_req_i.re2, rd_req_i.rs2, haz2);
        exp_stall         = rd_req_i.valid && (haz1 || haz2);
        exp_issue_d.valid = rd_req_i.valid && !exp_stall && !flush_i;
        exp_issue_d.op_a  = op1;
        exp_issue_d.op_b  = op2;
        n_stall  += int'(exp_stall);
        n_flush  += int'(rd_req_i.valid && !exp_stall && flush_i);
        n_accept += int'(exp_issue_d.valid);
        // several stages writing the source that is read
        hits = int'(ex_wr_i.we && (ex_wr_i.waddr == rd_req_i.rs1)) +
               int'(mem_wr_i.we && (mem_wr_i.waddr == rd_req_i.rs1)) +
               int'(wb_wr_i.we && (wb_wr_i.waddr == rd_req_i.rs1));
        if (exp_issue_d.valid && rd_req_i.re1 && (rd_req_i.rs1 != '0) && (hits >= 2)) begin
            n_multi++;
        end
    endtask

    // pipeline moves on and a stall puts a bubble into ex
    task automatic advance_stages(input logic bubble);
        wb_wr_i  = mem_wr_i;
        mem_wr_i = ex_wr_i;
        if (ex_wr_i.is_load) begin
            mem_wr_i.wdata = $urandom;
        end
        mem_wr_i.is_load = 1'b0;
        if (bubble) begin
            ex_wr_i = '0;
        end else begin
            ex_wr_i.we      = ($urandom % 4) != 0;
            ex_wr_i.is_load = ex_wr_i.we && (($urandom % 3) == 0);
            ex_wr_i.waddr   = reg_addr_t'($urandom_range(0, 3));
            ex_wr_i.wdata   = $urandom;
        end
    endtask

    task automatic draw_request(input int max_addr);
        rd_req_i.valid = ($urandom % 5) != 0;
        rd_req_i.rs1   = reg_addr_t'($urandom_range(0, max_addr));
        rd_req_i.re1   = ($urandom % 6) != 0;
        rd_req_i.rs2   = reg_addr_t'($urandom_range(0, max_addr));
        rd_req_i.re2   = ($urandom % 6) != 0;
        n_req++;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0t", WATCHDOG_NS);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(SEED));
        rd_req_i     = '0;
        ex_wr_i      = '0;
        mem_wr_i     = '0;
        wb_wr_i      = '0;
        flush_i      = 1'b0;
        exp_stall    = 1'b0;
        exp_issue_d  = '0;
        stalled_prev = 1'b0;
        n_req        = 0;
        n_stall      = 0;
        n_flush      = 0;
        n_accept     = 0;
        n_multi      = 0;
        wait (rst_n);

        // with idle stages the whole file reads zero
        repeat (INIT_CYCLES) begin
            @(negedge clk);
            draw_request(NUM_REGS - 1);
            compute_expected();
        end

        while ((n_req < NUM_REQ + INIT_CYCLES) || stalled_prev) begin
            @(negedge clk);
            advance_stages(stalled_prev);
            if (!stalled_prev) begin
                draw_request(3);
            end
            flush_i = ($urandom % 16) == 0;
            compute_expected();
            stalled_prev = exp_stall;
        end

        // drain
        @(negedge clk);
        rd_req_i = '0;
        ex_wr_i  = '0;
        mem_wr_i = '0;
        wb_wr_i  = '0;
        flush_i  = 1'b0;
        compute_expected();
        repeat (3) @(negedge clk);

        if ((n_stall == 0) || (n_flush == 0) || (n_accept == 0) || (n_multi == 0)) begin
            $display("stimulus missed a case: stalls %0d, flushes %0d, issues %0d, multi hits %0d",
                     n_stall, n_flush, n_accept, n_multi);
            $display(">>> FAIL");
            $fatal(1, "incomplete stimulus");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src.f
rf_pkg.sv
reg_file.sv
bypass_select.sv
issue_reg.sv
operand_fetch.sv
tb_clock_gen.sv
tb_operand_fetch.sv
